// ==== list.f ====
source/soc_bus_pkg.sv
source/soc_irq_pkg.sv
source/bus_pipe_stage.sv
source/host_port.sv
source/addr_decoder.sv
source/main_memory.sv
source/irq_controller.sv
source/uninasoc.sv
test/tb_uninasoc.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the bus testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_uninasoc -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi

// ==== source/addr_decoder.sv ====
////////////////////////////////////////////////////////////
// address decoder, one request outstanding at a time
// targets must reply exactly one cycle after their strobe
// unmapped accesses get err with zero data, no side effect
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module addr_decoder (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    // request from pipe stage
    input  logic                                req_valid_i,
    input  soc_bus_pkg::bus_req_t               req_i,
    output logic                                req_ready_o,
    // target side
    output logic                                mem_sel_o,
    output logic                                irq_sel_o,
    output logic                                tgt_we_o,
    output logic [soc_bus_pkg::ADDR_WIDTH-1:0]  tgt_addr_o,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]  tgt_wdata_o,
    input  logic                                mem_rsp_valid_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  mem_rdata_i,
    input  logic                                irq_rsp_valid_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  irq_rdata_i,
    input  logic                                irq_err_i,
    // response to pipe stage
    output logic                                rsp_valid_o,
    output soc_bus_pkg::bus_rsp_t               rsp_o,
    input  logic                                rsp_ready_i
);

    localparam logic [soc_bus_pkg::ADDR_WIDTH-1:0] MEM_SPAN = soc_bus_pkg::MEM_WORDS * 4;

    logic                 outstanding_q;
    soc_bus_pkg::target_e tgt, tgt_q;
    logic                 accept;

    // offset compare, wraps safely for any base
    always_comb begin
        if (tgt_addr_o - soc_bus_pkg::MEM_BASE < MEM_SPAN)
            tgt = soc_bus_pkg::TGT_MEM;
        else if (tgt_addr_o - soc_bus_pkg::IRQ_BASE < soc_bus_pkg::IRQ_SPAN)
            tgt = soc_bus_pkg::TGT_IRQ;
        else
            tgt = soc_bus_pkg::TGT_NONE;
    end

    assign {tgt_we_o, tgt_addr_o, tgt_wdata_o} = req_i;

    // rsp stage ready now means it has room next cycle too
    assign req_ready_o = rsp_ready_i & ~outstanding_q;
    assign accept      = req_valid_i & req_ready_o;

    assign mem_sel_o = accept & (tgt == soc_bus_pkg::TGT_MEM);
    assign irq_sel_o = accept & (tgt == soc_bus_pkg::TGT_IRQ);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            outstanding_q <= 1'b0;
            tgt_q         <= soc_bus_pkg::TGT_NONE;
        end else if (accept) begin
            outstanding_q <= 1'b1;
            tgt_q         <= tgt;
        end else if (rsp_valid_o) begin
            outstanding_q <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // response merge
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (tgt_q)
            soc_bus_pkg::TGT_MEM: begin
                rsp_valid_o = outstanding_q & mem_rsp_valid_i;
                rsp_o       = {1'b0, mem_rdata_i};
            end
            soc_bus_pkg::TGT_IRQ: begin
                rsp_valid_o = outstanding_q & irq_rsp_valid_i;
                rsp_o       = {irq_err_i, irq_rdata_i};
            end
            default: begin
                rsp_valid_o = outstanding_q;    // local error reply
                rsp_o       = {1'b1, {soc_bus_pkg::DATA_WIDTH{1'b0}}};
            end
        endcase
    end

endmodule : addr_decoder

// ==== source/bus_pipe_stage.sv ====
////////////////////////////////////////////////////////////
// one entry valid/ready register stage
// ready_o is combinational from ready_i (no skid buffer)
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    // upstream
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     ready_o,
    // downstream
    output logic     valid_o,
    output payload_t data_o,
    input  logic     ready_i
);

    logic     valid_q;
    payload_t data_q;
    logic     load;

    // empty, or draining this cycle
    assign ready_o = ~valid_q | ready_i;
    assign load    = valid_i & ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;   // refill or go empty
        end
    end

    // payload only moves on a handshake
    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule : bus_pipe_stage

// ==== source/host_port.sv ====
////////////////////////////////////////////////////////////
// four-phase req/ack host side to internal valid/ready
// one request per req_i level, host waits for ack_o low
// response stays in the rsp stage until req_i falls
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module host_port (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    // external four-phase side
    input  logic                                req_i,
    input  logic                                we_i,
    input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  addr_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  wdata_i,
    output logic                                ack_o,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]  rdata_o,
    output logic                                err_o,
    // internal request out
    output logic                                req_valid_o,
    output soc_bus_pkg::bus_req_t               req_o,
    input  logic                                req_ready_i,
    // internal response in
    input  logic                                rsp_valid_i,
    input  soc_bus_pkg::bus_rsp_t               rsp_i,
    output logic                                rsp_ready_o
);

    typedef enum logic [1:0] {
        ST_IDLE,     // waiting for req_i
        ST_ISSUED,   // request launched, waiting for reply
        ST_ACKED     // ack_o high until req_i drops
    } state_e;

    state_e                              state_q, state_d;
    logic [soc_bus_pkg::DATA_WIDTH-1:0]  rdata_q;
    logic                                err_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:   if (req_i && req_ready_i) state_d = ST_ISSUED;
            ST_ISSUED: if (rsp_valid_i)          state_d = ST_ACKED;
            ST_ACKED:  if (!req_i)               state_d = ST_IDLE;
            default:                             state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture reply, held stable for the whole ack phase
    always_ff @(posedge clk_i) begin
        if (state_q == ST_ISSUED && rsp_valid_i) begin
            {err_q, rdata_q} <= rsp_i;
        end
    end

    assign req_valid_o = (state_q == ST_IDLE) & req_i;     // only in idle
    assign req_o       = {we_i, addr_i, wdata_i};
    assign rsp_ready_o = (state_q == ST_ACKED) & ~req_i;   // pop on req fall

    assign ack_o   = (state_q == ST_ACKED);
    assign rdata_o = rdata_q;
    assign err_o   = err_q;

endmodule : host_port

// ==== source/irq_controller.sv ====
////////////////////////////////////////////////////////////
// minimal interrupt controller, edge triggered sources
// no priorities or threshold, claim picks the lowest id
// illegal accesses reply with err and change nothing
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module irq_controller (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic [soc_irq_pkg::NUM_SRC-1:0]     irq_src_i,
    input  logic                                sel_i,
    input  logic                                we_i,
    input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  addr_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  wdata_i,
    output logic                                rsp_valid_o,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]  rdata_o,
    output logic                                err_o,
    output logic                                irq_o
);

    logic [soc_irq_pkg::NUM_SRC-1:0]       src_q, pending_q, enable_q;
    logic [soc_irq_pkg::NUM_SRC-1:0]       rise, active, claim_mask;
    logic [soc_irq_pkg::SRC_ID_WIDTH-1:0]  claim_id;
    logic [soc_irq_pkg::REG_OFF_WIDTH-1:0] reg_off;
    logic                                  rd_ok, wr_enable, rd_claim;
    logic [soc_bus_pkg::DATA_WIDTH-1:0]    rd_data, rdata_q;
    logic                                  rsp_valid_q, err_q;

    assign rise    = irq_src_i & ~src_q;
    assign active  = pending_q & enable_q;
    assign reg_off = {addr_i[soc_irq_pkg::REG_OFF_WIDTH-1:2], 2'b00};

    // lowest active line wins
    always_comb begin
        claim_id = '0;
        for (int n = soc_irq_pkg::NUM_SRC - 1; n >= 0; n--) begin
            if (active[n]) claim_id = soc_irq_pkg::SRC_ID_WIDTH'(n + 1);
        end
    end

    ////////////////////////////////////////////////////////////
    // access decode
    ////////////////////////////////////////////////////////////

    assign rd_ok     = ~we_i & (reg_off == soc_irq_pkg::REG_PENDING ||
                                reg_off == soc_irq_pkg::REG_ENABLE  ||
                                reg_off == soc_irq_pkg::REG_CLAIM);
    assign wr_enable = sel_i & we_i & (reg_off == soc_irq_pkg::REG_ENABLE);
    assign rd_claim  = sel_i & ~we_i & (reg_off == soc_irq_pkg::REG_CLAIM);

    always_comb begin
        claim_mask = '0;
        for (int n = 0; n < soc_irq_pkg::NUM_SRC; n++) begin
            // line n owns id n+1
            if (rd_claim && claim_id == soc_irq_pkg::SRC_ID_WIDTH'(n + 1)) begin
                claim_mask[n] = 1'b1;
            end
        end
        rd_data = '0;
        if (rd_ok) begin
            case (reg_off)
                soc_irq_pkg::REG_PENDING: rd_data = soc_bus_pkg::DATA_WIDTH'(pending_q);
                soc_irq_pkg::REG_ENABLE:  rd_data = soc_bus_pkg::DATA_WIDTH'(enable_q);
                default:                  rd_data = soc_bus_pkg::DATA_WIDTH'(claim_id);
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            src_q       <= '0;
            pending_q   <= '0;
            enable_q    <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            src_q       <= irq_src_i;
            pending_q   <= (pending_q & ~claim_mask) | rise;   // new edge beats claim
            rsp_valid_q <= sel_i;
            if (wr_enable) enable_q <= wdata_i[soc_irq_pkg::NUM_SRC-1:0];
        end
    end

    // reply payload
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rdata_q <= rd_data;
            err_q   <= ~(rd_ok | wr_enable);
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rdata_o     = rdata_q;
    assign err_o       = err_q;
    assign irq_o       = |active;

endmodule : irq_controller

// ==== source/main_memory.sv ====
////////////////////////////////////////////////////////////
// word addressed RAM, MEM_WORDS deep, reply one cycle after sel_i
// upper address bits are not checked, the decoder does that
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module main_memory (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                sel_i,
    input  logic                                we_i,
    input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  addr_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  wdata_i,
    output logic                                rsp_valid_o,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]  rdata_o
);

    localparam int IDX_WIDTH = $clog2(soc_bus_pkg::MEM_WORDS);

    logic [soc_bus_pkg::DATA_WIDTH-1:0] mem [soc_bus_pkg::MEM_WORDS];
    logic [IDX_WIDTH-1:0]               idx;
    logic                               rsp_valid_q;
    logic [soc_bus_pkg::DATA_WIDTH-1:0] rdata_q;

    assign idx = addr_i[IDX_WIDTH+1:2];    // drop byte offset

    ////////////////////////////////////////////////////////////
    // storage and read port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            if (we_i) begin
                mem[idx] <= wdata_i;
                rdata_q  <= '0;            // writes return zero
            end else begin
                rdata_q  <= mem[idx];
            end
        end
    end

    // reply strobe
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= sel_i;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rdata_o     = rdata_q;

endmodule : main_memory

// ==== source/soc_bus_pkg.sv ====
////////////////////////////////////////////////////////////
// system bus widths, address map and payload types
// payloads are flat vectors, full words only (no strobes)
// the low two address bits are ignored everywhere
////////////////////////////////////////////////////////////

package soc_bus_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;

    // request is {we, addr, wdata}
    localparam int REQ_WIDTH  = 1 + ADDR_WIDTH + DATA_WIDTH;   // 65
    // response is {err, rdata}
    localparam int RSP_WIDTH  = 1 + DATA_WIDTH;                // 33

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////

    localparam logic [ADDR_WIDTH-1:0] MEM_BASE = 32'h0000_0000;
    localparam int                    MEM_WORDS = 256;          // 1 KiB

    localparam logic [ADDR_WIDTH-1:0] IRQ_BASE = 32'h0C00_0000;
    localparam int                    IRQ_SPAN = 16;            // bytes

    ////////////////////////////////////////////////////////////
    // payload types
    ////////////////////////////////////////////////////////////

    typedef logic [REQ_WIDTH-1:0] bus_req_t;
    typedef logic [RSP_WIDTH-1:0] bus_rsp_t;

    // decoder target select
    typedef enum logic [1:0] {
        TGT_MEM  = 2'd0,
        TGT_IRQ  = 2'd1,
        TGT_NONE = 2'd2    // unmapped, error reply
    } target_e;

endpackage : soc_bus_pkg

// ==== source/soc_irq_pkg.sv ====
////////////////////////////////////////////////////////////
// interrupt controller sizing and register map
// line n has source id n+1, id 0 means no interrupt
////////////////////////////////////////////////////////////

package soc_irq_pkg;

    // peripheral interrupt lines
    localparam int NUM_SRC      = 4;
    localparam int SRC_ID_WIDTH = 3;    // ids 0..NUM_SRC

    ////////////////////////////////////////////////////////////
    // register offsets inside the 16 byte window
    ////////////////////////////////////////////////////////////

    localparam int REG_OFF_WIDTH = 4;

    // read only, bit n pending for line n
    localparam logic [REG_OFF_WIDTH-1:0] REG_PENDING = 4'h0;
    // read/write, bit n enables line n
    localparam logic [REG_OFF_WIDTH-1:0] REG_ENABLE  = 4'h4;
    // read only, returns and clears lowest active id
    localparam logic [REG_OFF_WIDTH-1:0] REG_CLAIM   = 4'h8;

endpackage : soc_irq_pkg

// ==== source/uninasoc.sv ====
////////////////////////////////////////////////////////////
// system bus top, single host over a four-phase handshake
// targets are main memory and the interrupt controller
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uninasoc (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                req_i,
    input  logic                                we_i,
    input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  addr_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  wdata_i,
    output logic                                ack_o,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]  rdata_o,
    output logic                                err_o,
    input  logic [soc_irq_pkg::NUM_SRC-1:0]     irq_src_i,
    output logic                                irq_o
);

    ////////////////////////////////////////////////////////////
    // local signals
    ////////////////////////////////////////////////////////////

    // host -> req stage -> decoder
    logic                  hp_req_valid, req_stage_ready;
    soc_bus_pkg::bus_req_t hp_req, dec_req;
    logic                  dec_req_valid, dec_req_ready;
    // decoder -> rsp stage -> host
    logic                  dec_rsp_valid, rsp_stage_ready;
    soc_bus_pkg::bus_rsp_t dec_rsp, hp_rsp;
    logic                  hp_rsp_valid, hp_rsp_ready;
    // decoder <-> targets
    logic                               mem_sel, irq_sel, tgt_we;
    logic [soc_bus_pkg::ADDR_WIDTH-1:0] tgt_addr;
    logic [soc_bus_pkg::DATA_WIDTH-1:0] tgt_wdata, mem_rdata, irq_rdata;
    logic                               mem_rsp_valid, irq_rsp_valid, irq_err;

    host_port u_host_port (
        .clk_i, .arst_n_i, .req_i, .we_i, .addr_i, .wdata_i, .ack_o, .rdata_o, .err_o,
        .req_valid_o ( hp_req_valid    ),
        .req_o       ( hp_req          ),
        .req_ready_i ( req_stage_ready ),
        .rsp_valid_i ( hp_rsp_valid    ),
        .rsp_i       ( hp_rsp          ),
        .rsp_ready_o ( hp_rsp_ready    )
    );

    bus_pipe_stage #(.payload_t(soc_bus_pkg::bus_req_t)) u_req_stage (
        .clk_i, .arst_n_i,
        .valid_i ( hp_req_valid    ), .data_i ( hp_req  ), .ready_o ( req_stage_ready ),
        .valid_o ( dec_req_valid   ), .data_o ( dec_req ), .ready_i ( dec_req_ready   )
    );

    addr_decoder u_addr_decoder (
        .clk_i, .arst_n_i,
        .req_valid_i ( dec_req_valid ), .req_i ( dec_req ), .req_ready_o ( dec_req_ready ),
        .mem_sel_o       ( mem_sel       ),
        .irq_sel_o       ( irq_sel       ),
        .tgt_we_o        ( tgt_we        ),
        .tgt_addr_o      ( tgt_addr      ),
        .tgt_wdata_o     ( tgt_wdata     ),
        .mem_rsp_valid_i ( mem_rsp_valid ),
        .mem_rdata_i     ( mem_rdata     ),
        .irq_rsp_valid_i ( irq_rsp_valid ),
        .irq_rdata_i     ( irq_rdata     ),
        .irq_err_i       ( irq_err       ),
        .rsp_valid_o ( dec_rsp_valid ), .rsp_o ( dec_rsp ), .rsp_ready_i ( rsp_stage_ready )
    );

    bus_pipe_stage #(.payload_t(soc_bus_pkg::bus_rsp_t)) u_rsp_stage (
        .clk_i, .arst_n_i,
        .valid_i ( dec_rsp_valid ), .data_i ( dec_rsp ), .ready_o ( rsp_stage_ready ),
        .valid_o ( hp_rsp_valid  ), .data_o ( hp_rsp  ), .ready_i ( hp_rsp_ready    )
    );

    main_memory u_main_memory (
        .clk_i, .arst_n_i,
        .sel_i ( mem_sel ), .we_i ( tgt_we ), .addr_i ( tgt_addr ), .wdata_i ( tgt_wdata ),
        .rsp_valid_o ( mem_rsp_valid ), .rdata_o ( mem_rdata )
    );

    // external interrupt out stands in for the core line
    irq_controller u_irq_controller (
        .clk_i, .arst_n_i, .irq_src_i, .irq_o,
        .sel_i ( irq_sel ), .we_i ( tgt_we ), .addr_i ( tgt_addr ), .wdata_i ( tgt_wdata ),
        .rsp_valid_o ( irq_rsp_valid ), .rdata_o ( irq_rdata ), .err_o ( irq_err )
    );

endmodule : uninasoc

// ==== test/soc_cases.txt ====
// op irq_src addr wdata exp_rdata exp_err exp_irq, all hex
// op 1 bus read, 2 bus write, 3 irq_o check, exp_irq used by op 3 only
1 0 0C000004 00000000 00000000 0 0
2 0 00000010 DEADBEEF 00000000 0 0
1 0 00000010 00000000 DEADBEEF 0 0
1 0 00000013 00000000 DEADBEEF 0 0
2 0 000003FC 12345678 00000000 0 0
1 0 000003FC 00000000 12345678 0 0
2 0 00000000 A5A55A5A 00000000 0 0
2 0 00000400 FFFFFFFF 00000000 1 0
1 0 00000000 00000000 A5A55A5A 0 0
1 0 00000400 00000000 00000000 1 0
1 0 10000000 00000000 00000000 1 0
2 0 0C000010 00000001 00000000 1 0
1 0 0C00000C 00000000 00000000 1 0
3 1 00000000 00000000 00000000 0 0
1 1 0C000000 00000000 00000001 0 0
2 1 0C000004 0000000A 00000000 0 0
1 1 0C000004 00000000 0000000A 0 0
3 3 00000000 00000000 00000000 0 1
1 3 0C000000 00000000 00000003 0 0
3 B 00000000 00000000 00000000 0 1
1 B 0C000000 00000000 0000000B 0 0
1 B 0C000008 00000000 00000002 0 0
1 B 0C000008 00000000 00000004 0 0
1 B 0C000008 00000000 00000000 0 0
3 B 00000000 00000000 00000000 0 0
1 B 0C000000 00000000 00000001 0 0
2 B 0C000008 00000000 00000000 1 0
2 B 0C000000 0000000F 00000000 1 0
1 B 0C000000 00000000 00000001 0 0
2 B 0C000004 0000000F 00000000 0 0
3 B 00000000 00000000 00000000 0 1
1 B 0C000008 00000000 00000001 0 0
3 0 00000000 00000000 00000000 0 0

// ==== test/tb_uninasoc.sv ====
////////////////////////////////////////////////////////////
// testbench for the system bus top, replays test/soc_cases.txt
// run from the project root so the case file path resolves
// after the cases, lcg driven memory writes and readbacks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_uninasoc;

    localparam int CASE_COLS  = 7;     // op irq_src addr wdata exp_rdata exp_err exp_irq
    localparam int CASE_WORDS = 512;   // 9 bit index into case_mem
    localparam int MAX_CASES  = CASE_WORDS / CASE_COLS;
    localparam int N_RAND     = 16;    // random writes, each read back once
    localparam int ACK_LIMIT  = 16;    // cycles allowed per handshake edge
    localparam int IDX_W      = $clog2(soc_bus_pkg::MEM_WORDS);

    localparam logic [31:0] OP_READ  = 32'h1;
    localparam logic [31:0] OP_WRITE = 32'h2;
    localparam logic [31:0] OP_IRQ   = 32'h3;

    logic                               clk_i;
    logic                               arst_n_i;
    logic                               req_i, we_i;
    logic [soc_bus_pkg::ADDR_WIDTH-1:0] addr_i;
    logic [soc_bus_pkg::DATA_WIDTH-1:0] wdata_i, rdata_o;
    logic                               ack_o, err_o, irq_o;
    logic [soc_irq_pkg::NUM_SRC-1:0]    irq_src_i;

    logic [31:0]      case_mem  [CASE_WORDS];              // flat, CASE_COLS words per case
    logic [31:0]      score_mem [soc_bus_pkg::MEM_WORDS];  // expected memory words
    logic [IDX_W-1:0] rand_idx  [$];                       // word indexes hit by random writes
    int               n_cases      = 0;
    bit               cases_loaded = 1'b0;
    int               value_errors = 0;
    int               proto_errors = 0;

    uninasoc u_uninasoc (
        .clk_i, .arst_n_i, .req_i, .we_i, .addr_i, .wdata_i,
        .ack_o, .rdata_o, .err_o, .irq_src_i, .irq_o
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;    // 100 ns period
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // numerical recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] case_field(input int c, input int col);
        return case_mem[9'(c * CASE_COLS + col)];
    endfunction

    task automatic check_value(input string tag, input string what,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("[FAIL] %0t %s: %s got %h, expected %h", $time, tag, what, got, exp);
        end
    endtask

    // full four-phase transfer, ack phase held two extra cycles
    task automatic bus_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int          waited;
        logic [31:0] held;
        @(posedge clk_i);
        req_i   <= 1'b1;
        we_i    <= we;
        addr_i  <= addr;
        wdata_i <= wdata;
        waited  = 0;
        @(negedge clk_i);
        while (!ack_o && waited < ACK_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        assert (ack_o) else begin
            proto_errors++;
            $display("%0t: no ack_o within %0d cycles of raising req_i", $time, ACK_LIMIT);
        end
        rdata = rdata_o;
        err   = err_o;
        held  = rdata_o;
        repeat (2) begin
            @(negedge clk_i);
            assert (ack_o && rdata_o === held && err_o === err) else begin
                value_errors++;
                $display("[FAIL] %0t ack phase moved: ack_o %b rdata_o %h, held %h",
                         $time, ack_o, rdata_o, held);
            end
        end
        @(posedge clk_i);
        req_i  <= 1'b0;
        waited = 0;
        @(negedge clk_i);
        while (ack_o && waited < ACK_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        assert (!ack_o) else begin
            proto_errors++;
            $display("%0t: ack_o still high %0d cycles after req_i fell", $time, ACK_LIMIT);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin : main_seq
        logic [31:0]      op, src, addr, wdata, exp_rdata, exp_err, exp_irq;
        logic [31:0]      rdata, rng, data;
        logic             err;
        logic [IDX_W-1:0] idx;
        string            tag;

        arst_n_i  = 1'b0;
        req_i     = 1'b0;
        we_i      = 1'b0;
        addr_i    = '0;
        wdata_i   = '0;
        irq_src_i = '0;
        rng       = 32'h04e6_a196;

        for (int i = 0; i < CASE_WORDS; i++) begin
            case_mem[9'(i)] = '0;    // op 0 ends the list
        end
        $readmemh("test/soc_cases.txt", case_mem);
        while (n_cases < MAX_CASES && case_field(n_cases, 0) != '0) begin
            n_cases++;
        end
        cases_loaded = 1'b1;

        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value("reset", "ack_o", 32'(ack_o), 32'h0);
        check_value("reset", "irq_o", 32'(irq_o), 32'h0);

        // file cases
        for (int c = 0; c < n_cases; c++) begin
            op        = case_field(c, 0);
            src       = case_field(c, 1);
            addr      = case_field(c, 2);
            wdata     = case_field(c, 3);
            exp_rdata = case_field(c, 4);
            exp_err   = case_field(c, 5);
            exp_irq   = case_field(c, 6);
            tag       = $sformatf("case %0d", c);
            @(posedge clk_i);
            irq_src_i <= src[soc_irq_pkg::NUM_SRC-1:0];
            if (op == OP_READ || op == OP_WRITE) begin
                bus_access(op == OP_WRITE, addr, wdata, rdata, err);
                check_value(tag, "rdata_o", rdata, exp_rdata);
                check_value(tag, "err_o", 32'(err), exp_err);
            end else if (op == OP_IRQ) begin
                repeat (3) @(negedge clk_i);    // edge detect plus margin
                check_value(tag, "irq_o", 32'(irq_o), exp_irq);
            end else begin
                proto_errors++;
                $display("%s has unknown op %h, the case file is malformed", tag, op);
            end
        end

        // random sweep, later writes to one word overwrite the scoreboard
        for (int i = 0; i < N_RAND; i++) begin
            rng  = lcg_next(rng);
            idx  = rng[31 -: IDX_W];    // upper bits, better spread
            rng  = lcg_next(rng);
            data = rng;
            addr = soc_bus_pkg::MEM_BASE + (32'(idx) << 2);
            bus_access(1'b1, addr, data, rdata, err);
            tag  = $sformatf("random write %0d", i);
            check_value(tag, "err_o", 32'(err), 32'h0);
            score_mem[idx] = data;
            rand_idx.push_back(idx);
        end
        foreach (rand_idx[i]) begin
            addr = soc_bus_pkg::MEM_BASE + (32'(rand_idx[i]) << 2);
            bus_access(1'b0, addr, 32'h0, rdata, err);
            tag  = $sformatf("random read %0d", i);
            check_value(tag, "rdata_o", rdata, score_mem[rand_idx[i]]);
            check_value(tag, "err_o", 32'(err), 32'h0);
        end

        $display("value errors %0d, protocol errors %0d", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // budget of 20 cycles per case or random access
    initial begin : watchdog
        wait (cases_loaded);
        repeat ((n_cases + 2 * N_RAND) * 20) @(posedge clk_i);
        $display("run timed out after %0d cycles", (n_cases + 2 * N_RAND) * 20);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : tb_uninasoc
